// ==== include/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// one 64-bit instruction word per line
`define NUM_ICACHE_LINES 32
`define ICACHE_IDX_BITS  5

// fetch address layout is tag, index, then 3 byte-offset bits
`define MEM_ADDR_BITS    16
`define ICACHE_TAG_BITS  8

// tag 0 is reserved for "no request"
`define NUM_MEM_TAGS     16
`define MEM_TAG_BITS     4

`endif

// ==== hw/icache_pkg.sv ====
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_command_e;

  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_TAG_BITS-1:0] tag;
    logic [63:0]                 data;
  } icache_line_t;

  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_IDX_BITS-1:0] idx;
    logic [`ICACHE_TAG_BITS-1:0] tag;  // address tag the request was issued for
  } mem_tag_entry_t;

  typedef struct packed {
    logic [`ICACHE_TAG_BITS-1:0]                                   tag;
    logic [`ICACHE_IDX_BITS-1:0]                                   idx;
    logic [`MEM_ADDR_BITS-`ICACHE_TAG_BITS-`ICACHE_IDX_BITS-1:0] offset;
  } fetch_fields_t;

  // byte address for PC arithmetic, field view for the cache lookup
  typedef union packed {
    logic [`MEM_ADDR_BITS-1:0] raw;
    fetch_fields_t             fields;
  } fetch_addr_u;

endpackage

`default_nettype wire

// ==== hw/mem_tag_table.sv ====
`default_nettype none

`include "icache_defines.svh"

module mem_tag_table
  import icache_pkg::*;
(
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire logic                        i_alloc,
  input  wire logic [`MEM_TAG_BITS-1:0]    i_alloc_resp,
  input  wire logic [`ICACHE_IDX_BITS-1:0] i_alloc_idx,
  input  wire logic [`ICACHE_TAG_BITS-1:0] i_alloc_tag,
  input  wire logic [`MEM_TAG_BITS-1:0]    i_mem_tag,
  output logic                             o_ret_valid,
  output logic [`ICACHE_IDX_BITS-1:0]      o_ret_idx,
  output logic [`ICACHE_TAG_BITS-1:0]      o_ret_tag
);

  mem_tag_entry_t entries [`NUM_MEM_TAGS];
  mem_tag_entry_t ret_entry;

  assign ret_entry   = entries[i_mem_tag];
  assign o_ret_valid = (i_mem_tag != '0) && ret_entry.valid;
  assign o_ret_idx   = ret_entry.idx;
  assign o_ret_tag   = ret_entry.tag;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_MEM_TAGS; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      if (o_ret_valid) begin
        entries[i_mem_tag].valid <= 1'b0;  // free the entry that just returned
      end
      // a tag freed and reissued on the same edge ends up allocated
      if (i_alloc) begin
        entries[i_alloc_resp] <= '{valid: 1'b1, idx: i_alloc_idx, tag: i_alloc_tag};
      end
    end
  end

  // memory only hands out tags that have no request in flight
  a_alloc_free: assert property (@(posedge clock) disable iff (reset)
    i_alloc |-> (i_alloc_resp != '0) &&
                (!entries[i_alloc_resp].valid || (o_ret_valid && i_mem_tag == i_alloc_resp)))
    else $error("allocation onto a busy memory tag %0d", i_alloc_resp);

  a_ret_known: assert property (@(posedge clock) disable iff (reset)
    (i_mem_tag != '0) |-> ret_entry.valid)
    else $error("memory returned unknown tag %0d", i_mem_tag);

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache
  import icache_pkg::*;
(
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire fetch_addr_u                 i_fetch_addr,
  input  wire logic [`MEM_TAG_BITS-1:0]    i_mem_response,
  input  wire logic [`MEM_TAG_BITS-1:0]    i_mem_tag,
  input  wire logic [63:0]                 i_mem_data,
  input  wire logic                        i_ret_valid,
  input  wire logic [`ICACHE_IDX_BITS-1:0] i_ret_idx,
  input  wire logic [`ICACHE_TAG_BITS-1:0] i_ret_tag,
  output logic [63:0]                      o_inst,
  output logic                             o_inst_hit,
  output bus_command_e                     o_mem_command,
  output logic [`MEM_ADDR_BITS-1:0]        o_mem_addr,
  output logic                             o_alloc,
  output logic [`ICACHE_IDX_BITS-1:0]      o_alloc_idx,
  output logic [`ICACHE_TAG_BITS-1:0]      o_alloc_tag
);

  localparam int line_bits   = `ICACHE_TAG_BITS + `ICACHE_IDX_BITS;
  localparam int offset_bits = `MEM_ADDR_BITS - line_bits;

  icache_line_t lines [`NUM_ICACHE_LINES];

  logic [`ICACHE_IDX_BITS-1:0] head;
  logic [`ICACHE_IDX_BITS-1:0] tail;
  logic                        win_valid;  // window is empty until the first restart

  logic [`ICACHE_IDX_BITS-1:0] idx;
  logic [`ICACHE_TAG_BITS-1:0] tag;
  logic [`ICACHE_IDX_BITS-1:0] idx_plus_one;
  logic [`ICACHE_IDX_BITS-1:0] tail_plus_one;
  logic [`ICACHE_IDX_BITS-1:0] idx_dist;
  logic [`ICACHE_IDX_BITS-1:0] tail_dist;
  logic [`ICACHE_IDX_BITS-1:0] ahead;
  logic [line_bits-1:0]        pf_line;
  logic [`ICACHE_TAG_BITS-1:0] pf_tag;
  logic                        tag_match;
  logic                        in_window;
  logic                        run;
  logic                        window_full;
  logic                        tail_ready;
  logic                        mem_req;
  logic                        accepted;
  logic                        fill;

  assign idx = i_fetch_addr.fields.idx;
  assign tag = i_fetch_addr.fields.tag;

  assign tag_match  = lines[idx].tag == tag;
  assign o_inst_hit = lines[idx].valid && tag_match;
  assign o_inst     = lines[idx].data;

  assign idx_plus_one  = idx + 1'b1;
  assign tail_plus_one = tail + 1'b1;
  assign idx_dist      = idx - head;
  assign tail_dist     = tail - head;
  assign in_window     = win_valid && (idx_dist <= tail_dist);
  assign run           = in_window && tag_match;  // current line is filled or on its way

  // the window is sequential from the fetch line, so the tail address follows from it
  assign ahead   = tail - idx;
  assign pf_line = {tag, idx} + line_bits'(ahead);
  assign pf_tag  = pf_line[line_bits-1 -: `ICACHE_TAG_BITS];

  assign window_full = tail_plus_one == idx;
  assign tail_ready  = lines[tail].valid && (lines[tail].tag == pf_tag);
  assign mem_req     = run && !window_full && !tail_ready;
  assign accepted    = mem_req && (i_mem_response != '0);

  assign o_mem_command = mem_req ? BUS_LOAD : BUS_NONE;
  assign o_mem_addr    = {pf_line, {offset_bits{1'b0}}};
  assign o_alloc       = accepted;
  assign o_alloc_idx   = tail;
  assign o_alloc_tag   = pf_tag;

  // a return is dropped if its line was reallocated meanwhile
  assign fill = (i_mem_tag != '0) && i_ret_valid && (lines[i_ret_idx].tag == i_ret_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      win_valid <= 1'b0;
      head      <= '0;
      tail      <= '0;
    end else begin
      win_valid <= 1'b1;
      head      <= idx;
      if (!run) begin
        tail <= o_inst_hit ? idx_plus_one : idx;  // restart the window at the fetch line
      end else if (accepted || (!window_full && tail_ready)) begin
        tail <= tail_plus_one;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ICACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else begin
      if (fill) begin
        lines[i_ret_idx].data  <= i_mem_data;
        lines[i_ret_idx].valid <= 1'b1;
      end
      if (!run && !o_inst_hit) begin
        lines[idx].valid <= 1'b0;  // claim the missing line for the new tag
        lines[idx].tag   <= tag;
      end
      if (accepted) begin
        lines[tail].valid <= 1'b0;
        lines[tail].tag   <= pf_tag;
      end
    end
  end

  // a stalled fetch only starts hitting after its line came back from memory
  a_hit_after_fill: assert property (@(posedge clock) disable iff (reset)
    (o_inst_hit && !$past(o_inst_hit) && $stable(i_fetch_addr.raw))
      |-> $past(fill) && ($past(i_ret_idx) == idx))
    else $error("hit on line %0d without a fill", idx);

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`default_nettype none

`include "icache_defines.svh"

module fetch_stage
  import icache_pkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        i_redirect,
  input  wire fetch_addr_u i_redirect_pc,
  input  wire logic [63:0] i_cache_inst,
  input  wire logic        i_cache_hit,
  output fetch_addr_u      o_fetch_addr,
  output logic [63:0]      o_inst,
  output fetch_addr_u      o_inst_pc,
  output logic             o_inst_valid
);

  localparam logic [`MEM_ADDR_BITS-1:0] inst_step = 8;  // bytes per instruction word

  fetch_addr_u pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc.raw <= '0;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;
    end else if (i_cache_hit) begin
      pc.raw <= pc.raw + inst_step;  // a miss holds the PC until the line fills
    end
  end

  assign o_fetch_addr = pc;
  assign o_inst_pc    = pc;
  assign o_inst       = i_cache_inst;

  // the word at the old PC is dropped when a redirect arrives with it
  assign o_inst_valid = i_cache_hit && !i_redirect;

  // an unknown hit flag would let the PC step on garbage
  a_hit_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({i_redirect, i_cache_hit}))
    else $error("redirect or cache hit flag is unknown");

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`default_nettype none

`include "icache_defines.svh"

module fetch_top
  import icache_pkg::*;
(
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     i_redirect,
  input  wire fetch_addr_u              i_redirect_pc,
  input  wire logic [`MEM_TAG_BITS-1:0] i_mem_response,
  input  wire logic [`MEM_TAG_BITS-1:0] i_mem_tag,
  input  wire logic [63:0]              i_mem_data,
  output bus_command_e                  o_mem_command,
  output logic [`MEM_ADDR_BITS-1:0]     o_mem_addr,
  output logic [63:0]                   o_inst,
  output fetch_addr_u                   o_inst_pc,
  output logic                          o_inst_valid
);

  fetch_addr_u                 fetch_addr;
  logic [63:0]                 cache_inst;
  logic                        cache_hit;
  logic                        alloc;
  logic [`ICACHE_IDX_BITS-1:0] alloc_idx;
  logic [`ICACHE_TAG_BITS-1:0] alloc_tag;
  logic                        ret_valid;
  logic [`ICACHE_IDX_BITS-1:0] ret_idx;
  logic [`ICACHE_TAG_BITS-1:0] ret_tag;

  fetch_stage fetch_stage_i (
    .clock         (clock),
    .reset         (reset),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .i_cache_inst  (cache_inst),
    .i_cache_hit   (cache_hit),
    .o_fetch_addr  (fetch_addr),
    .o_inst        (o_inst),
    .o_inst_pc     (o_inst_pc),
    .o_inst_valid  (o_inst_valid)
  );

  icache icache_i (
    .clock          (clock),
    .reset          (reset),
    .i_fetch_addr   (fetch_addr),
    .i_mem_response (i_mem_response),
    .i_mem_tag      (i_mem_tag),
    .i_mem_data     (i_mem_data),
    .i_ret_valid    (ret_valid),
    .i_ret_idx      (ret_idx),
    .i_ret_tag      (ret_tag),
    .o_inst         (cache_inst),
    .o_inst_hit     (cache_hit),
    .o_mem_command  (o_mem_command),
    .o_mem_addr     (o_mem_addr),
    .o_alloc        (alloc),
    .o_alloc_idx    (alloc_idx),
    .o_alloc_tag    (alloc_tag)
  );

  // the response tag of an accepted request names the table entry
  mem_tag_table mem_tag_table_i (
    .clock        (clock),
    .reset        (reset),
    .i_alloc      (alloc),
    .i_alloc_resp (i_mem_response),
    .i_alloc_idx  (alloc_idx),
    .i_alloc_tag  (alloc_tag),
    .i_mem_tag    (i_mem_tag),
    .o_ret_valid  (ret_valid),
    .o_ret_idx    (ret_idx),
    .o_ret_tag    (ret_tag)
  );

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`default_nettype none

`include "icache_defines.svh"

module mem_model
  import icache_pkg::*;
#(
  parameter int          latency      = 4,
  parameter logic [63:0] data_pattern = 64'h0
) (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire logic                      i_busy_enable,
  input  wire bus_command_e              i_mem_command,
  input  wire logic [`MEM_ADDR_BITS-1:0] i_mem_addr,
  output logic [`MEM_TAG_BITS-1:0]       o_mem_response,
  output logic [`MEM_TAG_BITS-1:0]       o_mem_tag,
  output logic [63:0]                    o_mem_data
);

  logic [`MEM_TAG_BITS-1:0]  pipe_tag  [latency];
  logic [`MEM_ADDR_BITS-1:0] pipe_addr [latency];
  logic [`NUM_MEM_TAGS-1:0]  in_flight;
  logic [`MEM_TAG_BITS-1:0]  next_tag;
  logic [31:0]               lcg_state;
  logic                      busy;
  logic [`MEM_TAG_BITS-1:0]  take_tag;
  logic [`MEM_ADDR_BITS-1:0] take_addr;
  logic                      take_reset;
  logic                      take_busy_enable;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic clear_state();
    for (int k = 0; k < latency; k++) begin
      pipe_tag[k]  = '0;
      pipe_addr[k] = '0;
    end
    in_flight = '0;
    next_tag  = 1;
    lcg_state = 32'd23;
    busy      = 1'b0;
  endtask

  // a request is taken in its own cycle unless busy or the next tag is still out
  assign o_mem_response = (i_mem_command == BUS_LOAD && !busy && !in_flight[next_tag]) ?
                          next_tag : '0;
  assign o_mem_tag      = pipe_tag[latency-1];
  assign o_mem_data     = 64'(pipe_addr[latency-1] >> 3) ^ data_pattern;

  initial clear_state();

  always @(posedge clock) begin
    take_tag         = o_mem_response;  // values seen by the DUT on this edge
    take_addr        = i_mem_addr;
    take_reset       = reset;
    take_busy_enable = i_busy_enable;
    #1;
    if (take_reset) begin
      clear_state();
    end else begin
      for (int k = latency - 1; k > 0; k--) begin
        pipe_tag[k]  = pipe_tag[k-1];
        pipe_addr[k] = pipe_addr[k-1];
      end
      pipe_tag[0]  = take_tag;
      pipe_addr[0] = take_addr;
      if (take_tag != '0) begin
        next_tag = (next_tag == `NUM_MEM_TAGS - 1) ? 1 : next_tag + 1'b1;
      end
      lcg_state = lcg_next(lcg_state);
      busy      = take_busy_enable && lcg_state[16];  // about every other cycle
      in_flight = '0;
      for (int k = 0; k < latency; k++) begin
        in_flight[pipe_tag[k]] = 1'b1;
      end
      in_flight[0] = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/fetch_top_tb.sv ====
`default_nettype none

`include "icache_defines.svh"

module fetch_top_tb
  import icache_pkg::*;
();

  localparam logic [63:0] data_pattern    = 64'h5a3c_96f0_c3a5_0f00;
  localparam int          total_insts     = 94;  // 40 + 8 + 8 + 30 + 8 words over all tests
  localparam int          cycles_per_inst = 200;

  logic                      clock;
  logic                      reset;
  logic                      redirect;
  fetch_addr_u               redirect_pc;
  logic                      busy_enable;
  bus_command_e              mem_command;
  logic [`MEM_ADDR_BITS-1:0] mem_addr;
  logic [`MEM_TAG_BITS-1:0]  mem_response;
  logic [`MEM_TAG_BITS-1:0]  mem_tag;
  logic [63:0]               mem_data;
  logic [63:0]               inst;
  fetch_addr_u               inst_pc;
  logic                      inst_valid;

  fetch_top dut_i (
    .clock          (clock),
    .reset          (reset),
    .i_redirect     (redirect),
    .i_redirect_pc  (redirect_pc),
    .i_mem_response (mem_response),
    .i_mem_tag      (mem_tag),
    .i_mem_data     (mem_data),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .o_inst         (inst),
    .o_inst_pc      (inst_pc),
    .o_inst_valid   (inst_valid)
  );

  mem_model #(.latency(4), .data_pattern(data_pattern)) mem_i (
    .clock          (clock),
    .reset          (reset),
    .i_busy_enable  (busy_enable),
    .i_mem_command  (mem_command),
    .i_mem_addr     (mem_addr),
    .o_mem_response (mem_response),
    .o_mem_tag      (mem_tag),
    .o_mem_data     (mem_data)
  );

  always #5 clock = ~clock;

  // each memory word is its word address under a fixed mask
  function automatic logic [63:0] expected_word(input logic [`MEM_ADDR_BITS-1:0] pc);
    return 64'(pc >> 3) ^ data_pattern;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_inst(input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH o_inst got %h expected %h", got, exp));
    end
  endtask

  task automatic check_pc(input fetch_addr_u got, input fetch_addr_u exp);
    if (got.raw !== exp.raw) begin
      stop_with_failure($sformatf("MISMATCH o_inst_pc got %h expected %h", got.raw, exp.raw));
    end
  endtask

  task automatic check_command(input bus_command_e got, input bus_command_e exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH o_mem_command got %h expected %h", got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH o_inst_valid got %h expected %h", got, exp));
    end
  endtask

  task automatic next_valid();
    do begin
      @(negedge clock);
    end while (inst_valid !== 1'b1);
  endtask

  task automatic expect_stream(input logic [`MEM_ADDR_BITS-1:0] start_pc, input int count);
    fetch_addr_u pc;
    pc.raw = start_pc;
    for (int i = 0; i < count; i++) begin
      next_valid();
      check_pc(inst_pc, pc);
      check_inst(inst, expected_word(pc.raw));
      pc.raw = pc.raw + 8;
    end
  endtask

  task automatic redirect_to(input logic [`MEM_ADDR_BITS-1:0] addr);
    @(posedge clock);
    #1;
    redirect        = 1'b1;
    redirect_pc.raw = addr;
    @(negedge clock);
    check_valid(inst_valid, 1'b0);  // a hit in the strobe cycle is dropped
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  task automatic reset_values();
    repeat (15) begin
      @(negedge clock);
      check_command(mem_command, BUS_NONE);
      check_valid(inst_valid, 1'b0);
    end
    @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_command(mem_command, BUS_NONE);
    check_valid(inst_valid, 1'b0);
  endtask

  task automatic busy_stream();
    @(posedge clock);
    #1;
    busy_enable = 1'b1;
    redirect_to(16'h2800);
    expect_stream(16'h2800, 30);
    @(posedge clock);
    #1;
    busy_enable = 1'b0;
  endtask

  initial begin
    repeat (total_insts * cycles_per_inst) @(posedge clock);
    stop_with_failure("timeout: the instruction stream stalled before all tests finished");
  end

  initial begin
    clock           = 1'b0;
    reset           = 1'b1;
    redirect        = 1'b0;
    redirect_pc.raw = '0;
    busy_enable     = 1'b0;
    reset_values();
    expect_stream(16'h0000, 40);  // runs past line 31 so the prefetch window wraps
    redirect_to(16'h4000);
    expect_stream(16'h4000, 8);
    redirect_to(16'h7010);        // same index as the lines just filled, new tag
    expect_stream(16'h7010, 8);
    busy_stream();
    redirect_to(16'h2840);
    expect_stream(16'h2840, 8);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/icache_pkg.sv
hw/mem_tag_table.sv
hw/icache.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tb/mem_model.sv
tb/fetch_top_tb.sv
